//--- verilog/emesh_pkg.sv
package emesh_pkg;

  // field widths of one mesh transaction
  // access and write are single bits and need no width here

  // stream address, used for both dstaddr and srcaddr
  localparam int AW = 32;

  // data word carried with each transaction
  localparam int DW = 32;

  // translated destination address on the output side
  localparam int PAW = 64;

  // transfer size code
  localparam int DMW = 2;

  // ctrlmode bits, passed through untouched
  localparam int CMW = 4;

  // low dstaddr bits that bypass translation
  localparam int OFS_W = 20;

  // upper AW-OFS_W dstaddr bits select the table entry,
  // the page field then replaces them in the wider address

endpackage

//--- verilog/mmu_pkg.sv
package mmu_pkg;

  // translation table geometry

  // index bits, taken from the top of dstaddr
  localparam int IW = 12;

  // one entry per index value
  localparam int MD = 1 << IW;

  // page field, sized so page + offset fills the physical address
  localparam int MW = emesh_pkg::PAW - emesh_pkg::AW + IW;

  // stored entry = {valid, page}
  // valid sits at bit ENTRY_W-1, page in MW-1:0
  localparam int ENTRY_W = MW + 1;

  // dropped-transaction counter
  localparam int CNT_W = 16;

endpackage

//--- verilog/mmu_cfg_port.sv
`timescale 1ns/100ps

module mmu_cfg_port (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cfg_write,  // host write strobe
  input  logic                        cfg_read,   // host read strobe
  input  logic [mmu_pkg::IW-1:0]      cfg_addr,
  input  logic [mmu_pkg::ENTRY_W-1:0] cfg_wdata,
  input  logic [mmu_pkg::ENTRY_W-1:0] tb_rdata,   // port b data, one cycle after tb_addr
  output logic [mmu_pkg::ENTRY_W-1:0] cfg_rdata,
  output logic                        cfg_rvalid,
  output logic                        cfg_busy,   // high until the clear sweep is done
  output logic                        tb_we,
  output logic [mmu_pkg::IW-1:0]      tb_addr,
  output logic [mmu_pkg::ENTRY_W-1:0] tb_wdata
);

  logic [mmu_pkg::IW-1:0] clr_idx;  // sweep pointer
  logic                   clr_act;  // sweep owns port b this cycle
  logic                   host_wr;
  logic                   host_rd;

  // host strobes only count once the sweep has finished
  assign host_wr = cfg_write & ~cfg_busy;
  assign host_rd = cfg_read & ~cfg_write & ~cfg_busy;  // write wins

  // clear sweep, one entry per cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cfg_busy <= 1'b1;
      clr_act  <= 1'b0;
      clr_idx  <= '0;
    end
    else if (cfg_busy)
    begin
      if (!clr_act)
        clr_act <= 1'b1;  // first cycle after reset arms the sweep
      else
      begin
        clr_idx <= clr_idx + 1'b1;
        if (&clr_idx)  // last entry written, pointer wraps
        begin
          clr_act  <= 1'b0;
          cfg_busy <= 1'b0;  // never set again until next reset
        end
      end
    end
  end

  // read pending flag lines up with the table's registered read
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cfg_rvalid <= 1'b0;
    else
      cfg_rvalid <= host_rd;
  end

  assign cfg_rdata = tb_rdata;  // full entry incl valid bit

  // port b mux, sweep or host
  assign tb_we    = clr_act | host_wr;
  assign tb_addr  = clr_act ? clr_idx : cfg_addr;
  assign tb_wdata = clr_act ? '0 : cfg_wdata;  // zero entry = invalid

endmodule

//--- verilog/mmu_table.sv
`timescale 1ns/100ps

module mmu_table (
  input  logic                        clk,
  input  logic [mmu_pkg::IW-1:0]      lk_index,  // dstaddr[31:20]
  input  logic                        tb_we,
  input  logic [mmu_pkg::IW-1:0]      tb_addr,
  input  logic [mmu_pkg::ENTRY_W-1:0] tb_wdata,
  output logic [mmu_pkg::ENTRY_W-1:0] lk_entry,  // valid one cycle after lk_index
  output logic [mmu_pkg::ENTRY_W-1:0] tb_rdata
);

  // translation entries, {valid, page}
  // contents start undefined, the cfg port sweep zeroes them after reset
  logic [mmu_pkg::ENTRY_W-1:0] mem [mmu_pkg::MD];

  // port a, lookup only
  always_ff @(posedge clk)
  begin
    lk_entry <= mem[lk_index];  // sees the old entry on a same-cycle write
  end

  // port b, config read/write
  always_ff @(posedge clk)
  begin
    if (tb_we)
      mem[tb_addr] <= tb_wdata;
    tb_rdata <= mem[tb_addr];  // read-first
  end

endmodule

//--- verilog/emmu.sv
`timescale 1ns/100ps

module emmu (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         mmu_en,       // translation enable
  input  logic                         access_in,
  input  logic                         write_in,
  input  logic [emesh_pkg::DMW-1:0]    datamode_in,
  input  logic [emesh_pkg::CMW-1:0]    ctrlmode_in,
  input  logic [emesh_pkg::AW-1:0]     dstaddr_in,
  input  logic [emesh_pkg::AW-1:0]     srcaddr_in,
  input  logic [emesh_pkg::DW-1:0]     data_in,
  input  logic [mmu_pkg::ENTRY_W-1:0]  lk_entry,     // table entry for last cycle's dstaddr
  output logic                         xl_access,
  output logic                         xl_miss,
  output logic                         xl_write,
  output logic [emesh_pkg::DMW-1:0]    xl_datamode,
  output logic [emesh_pkg::CMW-1:0]    xl_ctrlmode,
  output logic [emesh_pkg::PAW-1:0]    xl_dstaddr,
  output logic [emesh_pkg::AW-1:0]     xl_srcaddr,
  output logic [emesh_pkg::DW-1:0]     xl_data
);

  logic                     access_q;
  logic                     en_q;      // mmu_en captured with the transaction
  logic [emesh_pkg::AW-1:0] dst_q;
  logic                     hit;

  // one stage to match the synchronous table read
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      access_q <= 1'b0;
      en_q     <= 1'b0;
    end
    else
    begin
      access_q <= access_in;
      en_q     <= mmu_en;
    end
  end

  // payload only moves with a transaction, holds otherwise
  always_ff @(posedge clk)
  begin
    if (access_in)
    begin
      xl_write    <= write_in;
      xl_datamode <= datamode_in;
      xl_ctrlmode <= ctrlmode_in;
      dst_q       <= dstaddr_in;
      xl_srcaddr  <= srcaddr_in;
      xl_data     <= data_in;
    end
  end

  assign hit = lk_entry[mmu_pkg::ENTRY_W-1];  // entry valid bit

  // bypass ignores the table entirely
  assign xl_miss   = access_q & en_q & ~hit;
  assign xl_access = access_q & ~xl_miss;  // missed transactions are dropped here

  // page replaces the index bits, offset passes through
  assign xl_dstaddr = en_q ?
                      {lk_entry[mmu_pkg::MW-1:0], dst_q[emesh_pkg::OFS_W-1:0]} :
                      {{(emesh_pkg::PAW-emesh_pkg::AW){1'b0}}, dst_q};

endmodule

//--- verilog/emesh_tx.sv
`timescale 1ns/100ps

module emesh_tx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        xl_access,
  input  logic                        xl_miss,
  input  logic                        xl_write,
  input  logic [emesh_pkg::DMW-1:0]   xl_datamode,
  input  logic [emesh_pkg::CMW-1:0]   xl_ctrlmode,
  input  logic [emesh_pkg::PAW-1:0]   xl_dstaddr,
  input  logic [emesh_pkg::AW-1:0]    xl_srcaddr,
  input  logic [emesh_pkg::DW-1:0]    xl_data,
  output logic                        access_out,
  output logic                        write_out,
  output logic [emesh_pkg::DMW-1:0]   datamode_out,
  output logic [emesh_pkg::CMW-1:0]   ctrlmode_out,
  output logic [emesh_pkg::PAW-1:0]   dstaddr_out,   // translated, 64 bits
  output logic [emesh_pkg::AW-1:0]    srcaddr_out,
  output logic [emesh_pkg::DW-1:0]    data_out,
  output logic [mmu_pkg::CNT_W-1:0]   miss_count
);

  // output valid, the only control bit on this side
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      access_out <= 1'b0;
    else
      access_out <= xl_access;  // receiver always ready
  end

  // fields keep their last values on idle and missed slots
  always_ff @(posedge clk)
  begin
    if (xl_access)
    begin
      write_out    <= xl_write;
      datamode_out <= xl_datamode;
      ctrlmode_out <= xl_ctrlmode;
      dstaddr_out  <= xl_dstaddr;
      srcaddr_out  <= xl_srcaddr;
      data_out     <= xl_data;
    end
  end

  // dropped transactions, sticks at all ones
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      miss_count <= '0;
    else if (xl_miss && !(&miss_count))
      miss_count <= miss_count + 1'b1;
  end

endmodule

//--- verilog/emmu_top.sv
`timescale 1ns/100ps

module emmu_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // stream in
  input  logic                        mmu_en,
  input  logic                        access_in,
  input  logic                        write_in,
  input  logic [emesh_pkg::DMW-1:0]   datamode_in,
  input  logic [emesh_pkg::CMW-1:0]   ctrlmode_in,
  input  logic [emesh_pkg::AW-1:0]    dstaddr_in,
  input  logic [emesh_pkg::AW-1:0]    srcaddr_in,
  input  logic [emesh_pkg::DW-1:0]    data_in,
  // stream out, two cycles behind
  output logic                        access_out,
  output logic                        write_out,
  output logic [emesh_pkg::DMW-1:0]   datamode_out,
  output logic [emesh_pkg::CMW-1:0]   ctrlmode_out,
  output logic [emesh_pkg::PAW-1:0]   dstaddr_out,
  output logic [emesh_pkg::AW-1:0]    srcaddr_out,
  output logic [emesh_pkg::DW-1:0]    data_out,
  output logic [mmu_pkg::CNT_W-1:0]   miss_count,
  // table config
  input  logic                        cfg_write,
  input  logic                        cfg_read,
  input  logic [mmu_pkg::IW-1:0]      cfg_addr,
  input  logic [mmu_pkg::ENTRY_W-1:0] cfg_wdata,
  output logic [mmu_pkg::ENTRY_W-1:0] cfg_rdata,
  output logic                        cfg_rvalid,
  output logic                        cfg_busy
);

  logic [mmu_pkg::ENTRY_W-1:0] lk_entry;
  logic                        tb_we;
  logic [mmu_pkg::IW-1:0]      tb_addr;
  logic [mmu_pkg::ENTRY_W-1:0] tb_wdata;
  logic [mmu_pkg::ENTRY_W-1:0] tb_rdata;

  // translator to output stage
  logic                        xl_access;
  logic                        xl_miss;
  logic                        xl_write;
  logic [emesh_pkg::DMW-1:0]   xl_datamode;
  logic [emesh_pkg::CMW-1:0]   xl_ctrlmode;
  logic [emesh_pkg::PAW-1:0]   xl_dstaddr;
  logic [emesh_pkg::AW-1:0]    xl_srcaddr;
  logic [emesh_pkg::DW-1:0]    xl_data;

  mmu_cfg_port u_cfg (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_write  (cfg_write),
    .cfg_read   (cfg_read),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .tb_rdata   (tb_rdata),
    .cfg_rdata  (cfg_rdata),
    .cfg_rvalid (cfg_rvalid),
    .cfg_busy   (cfg_busy),
    .tb_we      (tb_we),
    .tb_addr    (tb_addr),
    .tb_wdata   (tb_wdata)
  );

  // lookup index is the top of dstaddr, unregistered
  mmu_table u_table (
    .clk      (clk),
    .lk_index (dstaddr_in[emesh_pkg::AW-1 -: mmu_pkg::IW]),
    .tb_we    (tb_we),
    .tb_addr  (tb_addr),
    .tb_wdata (tb_wdata),
    .lk_entry (lk_entry),
    .tb_rdata (tb_rdata)
  );

  emmu u_emmu (
    .clk         (clk),
    .rst_n       (rst_n),
    .mmu_en      (mmu_en),
    .access_in   (access_in),
    .write_in    (write_in),
    .datamode_in (datamode_in),
    .ctrlmode_in (ctrlmode_in),
    .dstaddr_in  (dstaddr_in),
    .srcaddr_in  (srcaddr_in),
    .data_in     (data_in),
    .lk_entry    (lk_entry),
    .xl_access   (xl_access),
    .xl_miss     (xl_miss),
    .xl_write    (xl_write),
    .xl_datamode (xl_datamode),
    .xl_ctrlmode (xl_ctrlmode),
    .xl_dstaddr  (xl_dstaddr),
    .xl_srcaddr  (xl_srcaddr),
    .xl_data     (xl_data)
  );

  emesh_tx u_tx (
    .clk          (clk),
    .rst_n        (rst_n),
    .xl_access    (xl_access),
    .xl_miss      (xl_miss),
    .xl_write     (xl_write),
    .xl_datamode  (xl_datamode),
    .xl_ctrlmode  (xl_ctrlmode),
    .xl_dstaddr   (xl_dstaddr),
    .xl_srcaddr   (xl_srcaddr),
    .xl_data      (xl_data),
    .access_out   (access_out),
    .write_out    (write_out),
    .datamode_out (datamode_out),
    .ctrlmode_out (ctrlmode_out),
    .dstaddr_out  (dstaddr_out),
    .srcaddr_out  (srcaddr_out),
    .data_out     (data_out),
    .miss_count   (miss_count)
  );

endmodule

//--- bench/emmu_checker.sv
`timescale 1ns/100ps

module emmu_checker (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      cfg_write,
  input logic                      cfg_read,
  input logic                      cfg_busy,
  input logic                      cfg_rvalid,
  input logic                      access_out,
  input logic [mmu_pkg::CNT_W-1:0] miss_count
);

  int   fail_count = 0;  // assertion failures so far
  logic rd_ok;

  assign rd_ok = cfg_read & ~cfg_write & ~cfg_busy;  // read the port accepts

  rvalid_after_read: assert property (
    @(posedge clk) disable iff (!rst_n) rd_ok |=> cfg_rvalid)
  else
  begin
    $error("cfg_rvalid missing one cycle after a read");
    fail_count++;
  end

  rvalid_has_read: assert property (
    @(posedge clk) disable iff (!rst_n) cfg_rvalid |-> $past(rd_ok))
  else
  begin
    $error("cfg_rvalid without an accepted read");
    fail_count++;
  end

  // outputs with a reset must stay known
  out_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown({access_out, miss_count}))
  else
  begin
    $error("access_out or miss_count unknown");
    fail_count++;
  end

  busy_once: assert property (
    @(posedge clk) disable iff (!rst_n) !cfg_busy |=> !cfg_busy)
  else
  begin
    $error("cfg_busy rose after the sweep");
    fail_count++;
  end

endmodule

bind emmu_top emmu_checker u_checker (.*);

//--- bench/emmu_tb.sv
`timescale 1ns/100ps

module emmu_tb;

  typedef struct packed {
    logic                      access;
    logic                      miss;
    logic [6:0]                ctrl;  // {write, datamode, ctrlmode}
    logic [emesh_pkg::PAW-1:0] dst;
    logic [emesh_pkg::AW-1:0]  src;
    logic [emesh_pkg::DW-1:0]  data;
  } slot_t;

  localparam int CYCLE_LIMIT = 10000;  // 4096 sweep + ~2000 test cycles, margin

  logic                        clk, rst_n, mmu_en, access_in, write_in;
  logic                        cfg_write, cfg_read, cfg_rvalid, cfg_busy;
  logic                        access_out, write_out;
  logic [emesh_pkg::DMW-1:0]   datamode_in, datamode_out;
  logic [emesh_pkg::CMW-1:0]   ctrlmode_in, ctrlmode_out;
  logic [emesh_pkg::AW-1:0]    dstaddr_in, srcaddr_in, srcaddr_out;
  logic [emesh_pkg::DW-1:0]    data_in, data_out;
  logic [emesh_pkg::PAW-1:0]   dstaddr_out;
  logic [mmu_pkg::CNT_W-1:0]   miss_count;
  logic [mmu_pkg::IW-1:0]      cfg_addr;
  logic [mmu_pkg::ENTRY_W-1:0] cfg_wdata, cfg_rdata;

  logic [mmu_pkg::ENTRY_W-1:0] model_tbl [mmu_pkg::MD];  // mirror of the table
  logic [mmu_pkg::IW-1:0]      valid_idx[$];             // indices holding valid entries
  slot_t                       pending[$];               // slots in flight, oldest first
  logic [31:0]                 rng = 32'd75999;
  int                          model_miss = 0;
  int                          errors = 0;
  int                          cycles = 0;
  string                       test_name = "reset";

  emmu_top u_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    errors++;
    $display("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act);
  endtask

  task automatic write_entry(input logic [mmu_pkg::IW-1:0] idx,
                             input logic [mmu_pkg::ENTRY_W-1:0] val);
    cfg_write = 1'b1;
    cfg_addr  = idx;
    cfg_wdata = val;
    @(negedge clk);
    cfg_write = 1'b0;
    model_tbl[idx] = val;  // written at the edge just passed
  endtask

  task automatic read_entry(input logic [mmu_pkg::IW-1:0] idx);
    cfg_read = 1'b1;
    cfg_addr = idx;
    @(negedge clk);  // rvalid due exactly one cycle on
    cfg_read = 1'b0;
    if (cfg_rvalid !== 1'b1) report_mismatch("cfg_rvalid", 1, cfg_rvalid);
    if (cfg_rdata !== model_tbl[idx]) report_mismatch("cfg_rdata", model_tbl[idx], cfg_rdata);
  endtask

  task automatic check_slot(input slot_t e);
    if (e.miss)
      model_miss++;  // counter moves in the same slot
    if (access_out !== e.access) report_mismatch("access_out", e.access, access_out);
    if (e.access && dstaddr_out !== e.dst) report_mismatch("dstaddr_out", e.dst, dstaddr_out);
    if (e.access && {write_out, datamode_out, ctrlmode_out} !== e.ctrl)
      report_mismatch("write/datamode/ctrlmode", e.ctrl, {write_out, datamode_out, ctrlmode_out});
    if (e.access && srcaddr_out !== e.src) report_mismatch("srcaddr_out", e.src, srcaddr_out);
    if (e.access && data_out !== e.data) report_mismatch("data_out", e.data, data_out);
    if (miss_count !== model_miss) report_mismatch("miss_count", model_miss, miss_count);
  endtask

  // one stream cycle, result checked two falling edges later
  task automatic stream_slot(input logic acc, input logic [mmu_pkg::IW-1:0] idx);
    logic [31:0]                 r;
    logic [mmu_pkg::ENTRY_W-1:0] ent;
    slot_t                       exp;
    r           = next_rand();
    access_in   = acc;
    write_in    = r[0];
    datamode_in = r[2:1];
    ctrlmode_in = r[6:3];
    dstaddr_in  = {idx, r[31:12]};  // index on top, random offset
    srcaddr_in  = next_rand();
    data_in     = next_rand();
    ent         = model_tbl[idx];
    exp.miss    = acc & mmu_en & ~ent[mmu_pkg::ENTRY_W-1];
    exp.access  = acc & ~exp.miss;
    exp.ctrl    = {write_in, datamode_in, ctrlmode_in};
    exp.dst     = mmu_en ? {ent[mmu_pkg::MW-1:0], dstaddr_in[emesh_pkg::OFS_W-1:0]}
                         : {32'h0, dstaddr_in};  // page + offset, or zero-extended
    exp.src     = srcaddr_in;
    exp.data    = data_in;
    pending.push_back(exp);
    @(negedge clk);
    if (pending.size() > 1) check_slot(pending.pop_front());
  endtask

  task automatic drain();
    access_in = 1'b0;
    while (pending.size() > 0)
    begin
      @(negedge clk);
      check_slot(pending.pop_front());
    end
  endtask

  initial
  begin : stimulus
    logic [31:0]            r;
    logic [mmu_pkg::IW-1:0] idx;
    logic [mmu_pkg::IW-1:0] written[$];
    int                     sent;
    {rst_n, mmu_en, access_in, write_in, datamode_in, ctrlmode_in} = '0;
    {dstaddr_in, srcaddr_in, data_in, cfg_write, cfg_read, cfg_addr, cfg_wdata} = '0;
    foreach (model_tbl[i]) model_tbl[i] = '0;  // state after the clear sweep
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    if (cfg_busy !== 1'b1) report_mismatch("cfg_busy", 1, cfg_busy);
    while (cfg_busy === 1'b1) @(negedge clk);  // sweep, bounded by cycle limit

    test_name = "clear_sweep";
    repeat (32)
    begin
      r = next_rand();
      read_entry(r[mmu_pkg::IW-1:0]);
    end

    test_name = "write_readback";
    for (int i = 0; i < 64; i++)
    begin
      r = next_rand();
      written.push_back(r[mmu_pkg::IW-1:0]);
      write_entry(r[mmu_pkg::IW-1:0], {(i % 4 != 3), r[31:20], next_rand()});  // every 4th invalid
    end
    foreach (written[i]) read_entry(written[i]);
    foreach (written[i])
      if (model_tbl[written[i]][mmu_pkg::ENTRY_W-1]) valid_idx.push_back(written[i]);

    test_name = "write_read_same_cycle";
    r = next_rand();
    cfg_read = 1'b1;  // read strobe alongside the write
    write_entry(r[mmu_pkg::IW-1:0], {1'b1, r[31:20], next_rand()});
    cfg_read = 1'b0;
    if (cfg_rvalid !== 1'b0) report_mismatch("cfg_rvalid", 0, cfg_rvalid);
    read_entry(r[mmu_pkg::IW-1:0]);

    test_name = "translation";
    mmu_en = 1'b1;
    sent = 0;
    while (sent < 300)
    begin
      r = next_rand();
      if (r[1:0] != 2'b00)
      begin
        stream_slot(1'b1, valid_idx[r[31:8] % valid_idx.size()]);
        sent++;
      end
      else
        stream_slot(1'b0, r[31:20]);  // idle slot
    end
    drain();

    test_name = "miss";
    repeat (150)
    begin
      r = next_rand();
      idx = r[2] ? valid_idx[r[31:8] % valid_idx.size()] : r[31:20];  // mostly unwritten
      stream_slot(r[0] | r[1], idx);
    end
    drain();

    test_name = "bypass";
    mmu_en = 1'b0;
    repeat (200)
    begin
      r = next_rand();
      idx = r[2] ? valid_idx[r[31:8] % valid_idx.size()] : r[31:20];
      stream_slot(r[0] | r[1], idx);
    end
    drain();

    errors += u_dut.u_checker.fail_count;  // assertion failures count too
    $display("run complete, errors: %0d", errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- all.f
verilog/emesh_pkg.sv
verilog/mmu_pkg.sv
verilog/mmu_cfg_port.sv
verilog/mmu_table.sv
verilog/emmu.sv
verilog/emesh_tx.sv
verilog/emmu_top.sv
bench/emmu_checker.sv
bench/emmu_tb.sv
